//--- verilog/lsq_settings.svh
`ifndef LSQ_SETTINGS_SVH
`define LSQ_SETTINGS_SVH

// queue entries as a power of two so the pointers wrap on their own
`define LSQ_DEPTH 8

// result slots on the common data bus each cycle
`define NUM_CDB 2

// rob tag width where tag 0 marks an operand that is already known
`define TAG_WIDTH 4

// data and address width
`define DATA_WIDTH 32

// data memory size in words
`define MEM_WORDS 256

// resolved stores waiting for memory as a power of two
`define SB_DEPTH 4

`endif

//--- verilog/core_types_pkg.sv
`default_nettype none

`include "lsq_settings.svh"

package core_types_pkg;

    typedef logic [`TAG_WIDTH-1:0] tag_t;

    typedef enum logic {
        op_load,
        op_store
    } lsq_op_e;

    // one broadcast on the common data bus
    typedef struct packed {
        logic                   valid;
        tag_t                   tag;
        logic [`DATA_WIDTH-1:0] value;
    } cdb_slot_t;

    typedef cdb_slot_t [`NUM_CDB-1:0] cdb_t;

    // qj/vj hold the base, qk/vk the store data
    typedef struct packed {
        lsq_op_e                op;
        tag_t                   tag;
        tag_t                   qj;
        logic [`DATA_WIDTH-1:0] vj;
        tag_t                   qk;
        logic [`DATA_WIDTH-1:0] vk;
        logic [`DATA_WIDTH-1:0] offset;
    } lsq_entry_t;

    typedef struct packed {
        logic                   valid;
        tag_t                   tag;
        logic [`DATA_WIDTH-1:0] value;
    } result_t;

endpackage

`default_nettype wire

//--- verilog/mem_types_pkg.sv
`default_nettype none

`include "lsq_settings.svh"

package mem_types_pkg;

    // index of a word in data memory
    typedef logic [$clog2(`MEM_WORDS)-1:0] word_addr_t;

    typedef struct packed {
        logic                   valid;
        logic                   write;
        word_addr_t             addr;
        logic [`DATA_WIDTH-1:0] wdata;
    } mem_req_t;

    // store with address already resolved
    typedef struct packed {
        word_addr_t             addr;
        logic [`DATA_WIDTH-1:0] data;
    } store_rec_t;

    // whose access was granted last cycle
    typedef enum logic [1:0] {
        owner_none,
        owner_load,
        owner_store
    } mem_owner_e;

endpackage

`default_nettype wire

//--- verilog/load_store_queue.sv
`timescale 1ns/1ps
`default_nettype none

`include "lsq_settings.svh"

module load_store_queue (
    input  logic                         clk,
    input  logic                         reset,
    input  logic                         flush,
    input  logic                         load,
    input  core_types_pkg::lsq_entry_t   lsq_entry,
    input  core_types_pkg::cdb_t         cdb,
    input  logic                         sb_empty,
    input  logic                         sb_full,
    input  logic                         grant,
    input  logic                         rdata_valid,
    input  logic [`DATA_WIDTH-1:0]       rdata,
    output logic                         sb_push,
    output mem_types_pkg::store_rec_t    sb_rec,
    output mem_types_pkg::mem_req_t      mem_req,
    output core_types_pkg::result_t      load_res,
    output core_types_pkg::result_t      store_res,
    output logic                         full
);

    import core_types_pkg::*;
    import mem_types_pkg::*;

    localparam int PTR_W = $clog2(`LSQ_DEPTH);
    localparam int CNT_W = PTR_W + 1;

    typedef enum logic {
        ld_idle,
        ld_wait
    } ld_state_e;

    lsq_entry_t             entries [`LSQ_DEPTH];
    lsq_entry_t             head_entry;
    logic [PTR_W-1:0]       head;
    logic [PTR_W-1:0]       tail;
    logic [CNT_W-1:0]       count;
    ld_state_e              ld_state;
    logic [`DATA_WIDTH-1:0] eff_addr;
    logic                   head_valid;
    logic                   accept;
    logic                   store_go;
    logic                   load_ready;
    logic                   load_done;
    logic                   pop;

    // fill any operand whose tag is on the bus this cycle
    function automatic lsq_entry_t snoop(input lsq_entry_t e, input cdb_t bus);
        lsq_entry_t r;
        r = e;
        for (int s = 0; s < `NUM_CDB; s++) begin
            if (bus[s].valid && bus[s].tag != '0) begin
                if (e.qj == bus[s].tag) begin
                    r.qj = '0;
                    r.vj = bus[s].value;
                end
                if (e.qk == bus[s].tag) begin
                    r.qk = '0;
                    r.vk = bus[s].value;
                end
            end
        end
        return r;
    endfunction

    assign head_entry = entries[head];
    assign head_valid = (count != '0);
    assign full       = (count == CNT_W'(`LSQ_DEPTH));
    assign accept     = load && !full && !flush;
    assign eff_addr   = head_entry.vj + head_entry.offset;

    // store needs base and data, and room in the store buffer
    assign store_go = head_valid && head_entry.op == op_store &&
                      head_entry.qj == '0 && head_entry.qk == '0 &&
                      !sb_full && !flush;

    // loads wait for the buffer to drain so older stores are in memory
    assign load_ready = head_valid && head_entry.op == op_load &&
                        head_entry.qj == '0 && sb_empty && ld_state == ld_idle;

    assign load_done = (ld_state == ld_wait) && rdata_valid && !flush;
    assign pop       = store_go || load_done;

    assign sb_push     = store_go;
    assign sb_rec.addr = word_addr_t'(eff_addr >> 2);
    assign sb_rec.data = head_entry.vk;

    always_comb begin
        mem_req       = '0;
        mem_req.valid = load_ready;
        mem_req.write = 1'b0;
        mem_req.addr  = word_addr_t'(eff_addr >> 2);
    end

    // dispatch write overrides the snoop of the same slot
    always_ff @(posedge clk) begin
        for (int i = 0; i < `LSQ_DEPTH; i++) begin
            entries[i] <= snoop(entries[i], cdb);
        end
        if (accept) begin
            entries[tail] <= snoop(lsq_entry, cdb);
        end
    end

    always_ff @(posedge clk) begin
        if (reset || flush) begin
            head  <= '0;
            tail  <= '0;
            count <= '0;
        end else begin
            if (accept) begin
                tail <= tail + 1'b1;
            end
            if (pop) begin
                head <= head + 1'b1;
            end
            count <= count + CNT_W'(accept) - CNT_W'(pop);
        end
    end

    // load fsm waits for the word after its read is granted
    always_ff @(posedge clk) begin
        if (reset || flush) begin
            ld_state <= ld_idle;
        end else begin
            case (ld_state)
                ld_idle: begin
                    if (load_ready && grant) begin
                        ld_state <= ld_wait;
                    end
                end
                ld_wait: begin
                    if (rdata_valid) begin
                        ld_state <= ld_idle;
                    end
                end
                default: ld_state <= ld_idle;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            store_res <= '0;
            load_res  <= '0;
        end else begin
            store_res.valid <= store_go;
            store_res.tag   <= head_entry.tag;
            store_res.value <= eff_addr;
            load_res.valid  <= load_done;
            load_res.tag    <= head_entry.tag;
            load_res.value  <= rdata;
        end
    end

endmodule

`default_nettype wire

//--- verilog/store_buffer.sv
`timescale 1ns/1ps
`default_nettype none

`include "lsq_settings.svh"

module store_buffer (
    input  logic                      clk,
    input  logic                      reset,
    input  logic                      push,
    input  mem_types_pkg::store_rec_t rec_in,
    input  logic                      grant,
    output mem_types_pkg::mem_req_t   mem_req,
    output logic                      empty,
    output logic                      full
);

    import mem_types_pkg::*;

    localparam int PTR_W = $clog2(`SB_DEPTH);
    localparam int CNT_W = PTR_W + 1;

    store_rec_t       recs [`SB_DEPTH];
    store_rec_t       oldest;
    logic [PTR_W-1:0] rd_ptr;
    logic [PTR_W-1:0] wr_ptr;
    logic [CNT_W-1:0] count;
    logic             wr_en;
    logic             rd_en;

    assign empty  = (count == '0);
    assign full   = (count == CNT_W'(`SB_DEPTH));
    assign wr_en  = push && !full;
    assign rd_en  = grant && !empty;
    assign oldest = recs[rd_ptr];

    // oldest store keeps asking for the memory until granted
    assign mem_req.valid = !empty;
    assign mem_req.write = 1'b1;
    assign mem_req.addr  = oldest.addr;
    assign mem_req.wdata = oldest.data;

    always_ff @(posedge clk) begin
        if (wr_en) begin
            recs[wr_ptr] <= rec_in;
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            rd_ptr <= '0;
            wr_ptr <= '0;
            count  <= '0;
        end else begin
            if (wr_en) begin
                wr_ptr <= wr_ptr + 1'b1;
            end
            if (rd_en) begin
                rd_ptr <= rd_ptr + 1'b1;
            end
            count <= count + CNT_W'(wr_en) - CNT_W'(rd_en);
        end
    end

endmodule

`default_nettype wire

//--- verilog/mem_arbiter.sv
`timescale 1ns/1ps
`default_nettype none

`include "lsq_settings.svh"

module mem_arbiter (
    input  logic                    clk,
    input  logic                    reset,
    input  mem_types_pkg::mem_req_t load_req,
    input  mem_types_pkg::mem_req_t store_req,
    output logic                    load_grant,
    output logic                    store_grant,
    output mem_types_pkg::mem_req_t mem_req,
    input  logic [`DATA_WIDTH-1:0]  mem_rdata,
    output logic [`DATA_WIDTH-1:0]  rdata,
    output logic                    rdata_valid
);

    import mem_types_pkg::*;

    mem_owner_e owner;

    // loads have fixed priority over the store buffer
    assign load_grant  = load_req.valid;
    assign store_grant = store_req.valid && !load_req.valid;

    always_comb begin
        if (load_grant) begin
            mem_req = load_req;
        end else if (store_grant) begin
            mem_req = store_req;
        end else begin
            mem_req = '0;
        end
    end

    // owner of the registered read data in the next cycle
    always_ff @(posedge clk) begin
        if (reset) begin
            owner <= owner_none;
        end else if (load_grant) begin
            owner <= owner_load;
        end else if (store_grant) begin
            owner <= owner_store;
        end else begin
            owner <= owner_none;
        end
    end

    assign rdata_valid = (owner == owner_load);
    assign rdata       = mem_rdata;

endmodule

`default_nettype wire

//--- verilog/data_memory.sv
`timescale 1ns/1ps
`default_nettype none

`include "lsq_settings.svh"

module data_memory (
    input  logic                    clk,
    input  mem_types_pkg::mem_req_t req,
    output logic [`DATA_WIDTH-1:0]  rdata
);

    import mem_types_pkg::*;

    logic [`DATA_WIDTH-1:0] words [`MEM_WORDS];

    // memory starts out cleared
    initial begin
        for (int i = 0; i < `MEM_WORDS; i++) begin
            words[i] = '0;
        end
    end

    // single port, one access per cycle
    always_ff @(posedge clk) begin
        if (req.valid) begin
            if (req.write) begin
                words[req.addr] <= req.wdata;
            end else begin
                rdata <= words[req.addr];
            end
        end
    end

endmodule

`default_nettype wire

//--- verilog/lsq_top.sv
`timescale 1ns/1ps
`default_nettype none

`include "lsq_settings.svh"

module lsq_top (
    input  logic                       clk,
    input  logic                       reset,
    input  logic                       flush,
    input  logic                       load,
    input  core_types_pkg::lsq_entry_t lsq_entry,
    input  core_types_pkg::cdb_t       cdb,
    output core_types_pkg::result_t    load_res,
    output core_types_pkg::result_t    store_res,
    output logic                       full
);

    import mem_types_pkg::*;

    store_rec_t             sb_rec;
    mem_req_t               load_req;
    mem_req_t               store_req;
    mem_req_t               mem_req;
    logic                   sb_push;
    logic                   sb_empty;
    logic                   sb_full;
    logic                   load_grant;
    logic                   store_grant;
    logic                   rdata_valid;
    logic [`DATA_WIDTH-1:0] mem_rdata;
    logic [`DATA_WIDTH-1:0] rdata;

    load_store_queue u_lsq (
        .clk         (clk),
        .reset       (reset),
        .flush       (flush),
        .load        (load),
        .lsq_entry   (lsq_entry),
        .cdb         (cdb),
        .sb_empty    (sb_empty),
        .sb_full     (sb_full),
        .grant       (load_grant),
        .rdata_valid (rdata_valid),
        .rdata       (rdata),
        .sb_push     (sb_push),
        .sb_rec      (sb_rec),
        .mem_req     (load_req),
        .load_res    (load_res),
        .store_res   (store_res),
        .full        (full)
    );

    // stores drain here even across a flush
    store_buffer u_sb (
        .clk     (clk),
        .reset   (reset),
        .push    (sb_push),
        .rec_in  (sb_rec),
        .grant   (store_grant),
        .mem_req (store_req),
        .empty   (sb_empty),
        .full    (sb_full)
    );

    mem_arbiter u_arb (
        .clk         (clk),
        .reset       (reset),
        .load_req    (load_req),
        .store_req   (store_req),
        .load_grant  (load_grant),
        .store_grant (store_grant),
        .mem_req     (mem_req),
        .mem_rdata   (mem_rdata),
        .rdata       (rdata),
        .rdata_valid (rdata_valid)
    );

    data_memory u_mem (
        .clk   (clk),
        .req   (mem_req),
        .rdata (mem_rdata)
    );

endmodule

`default_nettype wire

//--- bench/lsq_tb.sv
`timescale 1ns/1ps
`default_nettype none

`include "lsq_settings.svh"

module lsq_tb;

    import core_types_pkg::*;

    localparam int WINDOW    = 16;
    localparam int N_RANDOM  = 60;
    localparam int N_FLUSH   = 20;
    localparam int N_AFTER   = 40;
    localparam int TOTAL_OPS = N_RANDOM + N_FLUSH + N_AFTER + `LSQ_DEPTH + 4;

    // one dispatched operation as the model expects it back
    typedef struct packed {
        logic                   is_store;
        logic [`TAG_WIDTH-1:0]  tag;
        logic [`TAG_WIDTH-1:0]  qj;
        logic [`TAG_WIDTH-1:0]  qk;
        logic [`DATA_WIDTH-1:0] addr;
        logic [`DATA_WIDTH-1:0] data;
    } op_rec_t;

    // producer result due on the cdb after delay cycles
    typedef struct packed {
        logic [`TAG_WIDTH-1:0]  tag;
        logic [`DATA_WIDTH-1:0] value;
        logic [7:0]             delay;
    } bcast_t;

    logic       clk;
    logic       reset;
    logic       flush;
    logic       load;
    lsq_entry_t lsq_entry;
    cdb_t       cdb;
    result_t    load_res;
    result_t    store_res;
    logic       full;

    op_rec_t                expect_q [$];
    bcast_t                 bcast_q [$];
    logic [`DATA_WIDTH-1:0] model_mem [WINDOW];
    bit                     tag_busy [1 << `TAG_WIDTH];
    integer                 seed;
    int                     errors;
    int                     checks;
    int                     tests_run;
    int                     accepted;
    bit                     cdb_hold;

    lsq_top dut (
        .clk       (clk),
        .reset     (reset),
        .flush     (flush),
        .load      (load),
        .lsq_entry (lsq_entry),
        .cdb       (cdb),
        .load_res  (load_res),
        .store_res (store_res),
        .full      (full)
    );

    initial clk = 1'b0;
    always #5 clk = ~clk;

    task automatic check(input string what, input logic [31:0] got, input logic [31:0] want);
        checks++;
        if (got !== want) begin
            errors++;
            $display("Error at %0t: %s is %h, expected %h", $time, what, got, want);
        end
    endtask

    function automatic logic [`TAG_WIDTH-1:0] alloc_tag();
        for (int t = 1; t < (1 << `TAG_WIDTH); t++) begin
            if (!tag_busy[t]) begin
                tag_busy[t] = 1'b1;
                return t[`TAG_WIDTH-1:0];
            end
        end
        return '0;
    endfunction

    task automatic pend_operand(input logic [`DATA_WIDTH-1:0] value,
                                output logic [`TAG_WIDTH-1:0] t);
        bcast_t b;
        t = alloc_tag();
        if (t != '0) begin
            b.tag   = t;
            b.value = value;
            b.delay = 8'({$random(seed)} % 16);
            bcast_q.push_back(b);
        end
    endtask

    // random word access inside the window with operands possibly late
    task automatic build_op(input int pend_pct, input bit force_pend, output bit ok,
                            output lsq_entry_t e, output op_rec_t r);
        logic [`DATA_WIDTH-1:0] base;
        logic [`TAG_WIDTH-1:0]  t;
        e  = '0;
        r  = '0;
        ok = 1'b0;
        r.tag = alloc_tag();
        if (r.tag == '0) begin
            return;
        end
        ok         = 1'b1;
        r.is_store = 1'($random(seed));
        r.addr     = ({$random(seed)} % WINDOW) * 4;
        r.data     = $random(seed);
        base       = $random(seed);
        e.op       = r.is_store ? op_store : op_load;
        e.tag      = r.tag;
        e.offset   = r.addr - base;
        e.vj       = base;
        e.vk       = r.is_store ? r.data : '0;
        if (force_pend || {$random(seed)} % 100 < pend_pct) begin
            pend_operand(base, t);
            if (t != '0) begin
                e.qj = t;
                e.vj = $random(seed);
                r.qj = t;
            end
        end
        if (r.is_store && {$random(seed)} % 100 < pend_pct) begin
            pend_operand(r.data, t);
            if (t != '0) begin
                e.qk = t;
                e.vk = $random(seed);
                r.qk = t;
            end
        end
    endtask

    task automatic dispatch(input bit offer, input int pend_pct, input bit force_pend);
        lsq_entry_t e;
        op_rec_t    r;
        bit         ok;
        load = 1'b0;
        if (!offer) begin
            return;
        end
        if (full) begin
            // the queue must drop an entry offered while full
            load = 1'b1;
            lsq_entry.offset = $random(seed);
            return;
        end
        build_op(pend_pct, force_pend, ok, e, r);
        if (ok) begin
            load      = 1'b1;
            lsq_entry = e;
            expect_q.push_back(r);
            accepted++;
        end
    endtask

    task automatic mark_seen(input logic [`TAG_WIDTH-1:0] t);
        op_rec_t r;
        for (int k = 0; k < expect_q.size(); k++) begin
            r = expect_q[k];
            if (r.qj == t) begin
                r.qj = '0;
            end
            if (r.qk == t) begin
                r.qk = '0;
            end
            expect_q[k] = r;
        end
    endtask

    task automatic drive_cdb();
        bcast_t b;
        int     slot;
        int     i;
        cdb  = '0;
        slot = 0;
        i    = 0;
        if (cdb_hold) begin
            return;
        end
        for (int k = 0; k < bcast_q.size(); k++) begin
            b = bcast_q[k];
            if (b.delay != 0) begin
                b.delay = b.delay - 8'd1;
            end
            bcast_q[k] = b;
        end
        while (i < bcast_q.size() && slot < `NUM_CDB) begin
            b = bcast_q[i];
            if (b.delay == 0) begin
                cdb[slot].valid = 1'b1;
                cdb[slot].tag   = b.tag;
                cdb[slot].value = b.value;
                mark_seen(b.tag);
                tag_busy[b.tag] = 1'b0;
                bcast_q.delete(i);
                slot++;
            end else begin
                i++;
            end
        end
    endtask

    // both kinds of result leave in program order through one queue
    task automatic watch_results();
        op_rec_t r;
        result_t res;
        if (!store_res.valid && !load_res.valid) begin
            return;
        end
        res = store_res.valid ? store_res : load_res;
        if (expect_q.size() == 0) begin
            errors++;
            $display("result for tag %0d at %0t with no operation outstanding", res.tag, $time);
            return;
        end
        r = expect_q.pop_front();
        check("result kind", 32'(store_res.valid), 32'(r.is_store));
        check("result tag", 32'(res.tag), 32'(r.tag));
        check("operands seen before result", 32'(r.qj == '0 && r.qk == '0), 32'(1));
        if (r.is_store) begin
            check("store address", res.value, r.addr);
            model_mem[r.addr[5:2]] = r.data;
        end else begin
            check("load data", res.value, model_mem[r.addr[5:2]]);
        end
        tag_busy[r.tag] = 1'b0;
    endtask

    task automatic cycle(input bit offer, input int pend_pct, input bit force_pend);
        @(negedge clk);
        watch_results();
        dispatch(offer, pend_pct, force_pend);
        drive_cdb();
    endtask

    task automatic drain();
        while (expect_q.size() != 0 || bcast_q.size() != 0) begin
            cycle(1'b0, 0, 1'b0);
        end
        // a few idle cycles to catch stray results
        repeat (4) cycle(1'b0, 0, 1'b0);
    endtask

    task automatic report_test(input string name, input int start_err);
        tests_run++;
        if (errors == start_err) begin
            $display("test %s: passed", name);
        end else begin
            $display("test %s: failed with %0d errors", name, errors - start_err);
        end
    endtask

    task automatic run_program(input string name, input int n_ops, input int pend_pct);
        int start_err;
        int start;
        start_err = errors;
        start     = accepted;
        while (accepted - start < n_ops) begin
            cycle({$random(seed)} % 4 != 0, pend_pct, 1'b0);
        end
        drain();
        report_test(name, start_err);
    endtask

    // head waits on its base so the queue only fills
    task automatic backpressure_test();
        int start_err;
        int start;
        start_err = errors;
        start     = accepted;
        cdb_hold  = 1'b1;
        cycle(1'b1, 0, 1'b1);
        repeat (`LSQ_DEPTH + 2) cycle(1'b1, 0, 1'b0);
        cycle(1'b0, 0, 1'b0);
        check("entries accepted while held", 32'(accepted - start), 32'(`LSQ_DEPTH));
        check("full while held", 32'(full), 32'(1));
        cdb_hold = 1'b0;
        drain();
        report_test("back-pressure", start_err);
    endtask

    task automatic flush_test();
        int start_err;
        int start;
        start_err = errors;
        start     = accepted;
        while (accepted - start < N_FLUSH) begin
            cycle(1'b1, 60, 1'b0);
        end
        @(negedge clk);
        watch_results();
        load  = 1'b0;
        flush = 1'b1;
        drive_cdb();
        @(negedge clk);
        flush = 1'b0;
        // flushed entries never report and give their tags back
        foreach (expect_q[k]) begin
            tag_busy[expect_q[k].tag] = 1'b0;
        end
        expect_q.delete();
        check("full after flush", 32'(full), 32'(0));
        watch_results();
        drive_cdb();
        drain();
        report_test("flush", start_err);
    endtask

    initial begin
        seed      = 32'hb086b094;
        reset     = 1'b1;
        flush     = 1'b0;
        load      = 1'b0;
        lsq_entry = '0;
        cdb       = '0;
        errors    = 0;
        checks    = 0;
        tests_run = 0;
        accepted  = 0;
        cdb_hold  = 1'b0;
        foreach (model_mem[i]) begin
            model_mem[i] = '0;
        end
        foreach (tag_busy[i]) begin
            tag_busy[i] = 1'b0;
        end
        repeat (5) @(negedge clk);
        reset = 1'b0;
        check("full after reset", 32'(full), 32'(0));
        check("load_res valid after reset", 32'(load_res.valid), 32'(0));
        check("store_res valid after reset", 32'(store_res.valid), 32'(0));
        report_test("reset values", 0);
        run_program("random program", N_RANDOM, 50);
        backpressure_test();
        flush_test();
        run_program("program after flush", N_AFTER, 40);
        $display("tests %0d, checks %0d, errors %0d", tests_run, checks, errors);
        if (errors == 0) begin
            $display("Everything OK");
        end else begin
            $display("Something failed");
        end
        $finish;
    end

    // about 50 cycles per operation
    initial begin
        repeat (TOTAL_OPS * 50) @(posedge clk);
        $display("timeout, the run did not finish within %0d cycles", TOTAL_OPS * 50);
        $display("Something failed");
        $finish;
    end

endmodule

`default_nettype wire

//--- compile.f
+incdir+verilog
verilog/core_types_pkg.sv
verilog/mem_types_pkg.sv
verilog/load_store_queue.sv
verilog/store_buffer.sv
verilog/mem_arbiter.sv
verilog/data_memory.sv
verilog/lsq_top.sv
bench/lsq_tb.sv

//--- Makefile
SIM = obj_dir/Vlsq_tb

.PHONY: all compile run clean

all: run

compile: $(SIM)

$(SIM): compile.f verilog/*.sv verilog/*.svh bench/*.sv
	verilator --binary --timing -Wno-fatal --top-module lsq_tb -f compile.f

run: $(SIM)
	./$(SIM) > run.log 2>&1; cat run.log
	grep -q "Everything OK" run.log

clean:
	rm -rf obj_dir run.log
